/* include/corr_ones_cfg.svh */
`ifndef CORR_ONES_CFG_SVH
`define CORR_ONES_CFG_SVH

// Sizing of the ones-counter block.

// Width of one accumulated count.
`define CORR_ACCUM_W 32

// Antenna lanes, each one bit per slot.
`define CORR_LANES 2

// Slots per pass of the time multiplexer.
`define CORR_SLOTS 12

// Full antenna word, all lanes side by side.
`define CORR_ANT_W (`CORR_LANES * `CORR_SLOTS)

// Bus and count memory address width.
`define CORR_ADR_W 5

`endif

/* logic/corr_ones_pkg.sv */
`include "corr_ones_cfg.svh"

package corr_ones_pkg;

   // One accumulated count.
   typedef logic [`CORR_ACCUM_W-1:0] count_t;

   // Raw antenna word. Lane 0 low, lane 1 high.
   typedef logic [`CORR_ANT_W-1:0] ant_word_t;

   // Slot index within one pass.
   typedef logic [$clog2(`CORR_SLOTS)-1:0] slot_t;

   // Count memory word address, bank bit then slot.
   typedef logic [`CORR_ADR_W-1:0] ram_addr_t;

   // Bus address, lane bit then slot.
   typedef logic [`CORR_ADR_W-1:0] bus_adr_t;

   // Readout bus states.
   typedef enum logic [1:0] {
      BUS_IDLE, // No cycle open.
      BUS_READ, // Address registered, memory read under way.
      BUS_ACK,  // Read data on the memory port.
      BUS_WAIT  // Ack sent, cycle still open.
   } bus_state_e;

endpackage

/* logic/count_ram_if.sv */
interface count_ram_if;
   import corr_ones_pkg::*;

   // Accumulator read port. Both lanes at once.
   ram_addr_t acc_rd_addr;
   count_t    acc_rd_data0;
   count_t    acc_rd_data1;

   // Accumulator write port. Same address for both lanes.
   logic      acc_wr_en;
   ram_addr_t acc_wr_addr;
   count_t    acc_wr_data0;
   count_t    acc_wr_data1;

   // Bus read port. One lane per access.
   ram_addr_t bus_rd_addr;
   logic      bus_rd_lane;     // 0 = lane 0, 1 = lane 1.
   count_t    bus_rd_data;

   modport acc (
      output acc_rd_addr, acc_wr_en, acc_wr_addr, acc_wr_data0, acc_wr_data1,
      input  acc_rd_data0, acc_rd_data1
   );

   modport rdout (
      output bus_rd_addr, bus_rd_lane,
      input  bus_rd_data
   );

   modport mem (
      input  acc_rd_addr, acc_wr_en, acc_wr_addr, acc_wr_data0, acc_wr_data1,
      input  bus_rd_addr, bus_rd_lane,
      output acc_rd_data0, acc_rd_data1, bus_rd_data
   );
endinterface

/* logic/count_bank_ram.sv */
`include "corr_ones_cfg.svh"

module count_bank_ram (
   input  logic    clk_x,
   count_ram_if.mem mem
);
   import corr_ones_pkg::*;

   // Two banks of 16 words per lane. Slots 12 to 15 are never written.
   localparam int depth = 2 ** `CORR_ADR_W;

   count_t lane0_mem [depth];  // Counts for antenna lane 0.
   count_t lane1_mem [depth];  // Counts for antenna lane 1.

   // --------------------------------------------------
   // Accumulator side
   // --------------------------------------------------

   // Read and write both lanes in parallel.
   // Registered read, one cycle from address to data.
   always_ff @(posedge clk_x) begin : acc_port
      if (mem.acc_wr_en) begin
         lane0_mem[mem.acc_wr_addr] <= mem.acc_wr_data0;
         lane1_mem[mem.acc_wr_addr] <= mem.acc_wr_data1;
      end
      mem.acc_rd_data0 <= lane0_mem[mem.acc_rd_addr];  // Old data on a clash.
      mem.acc_rd_data1 <= lane1_mem[mem.acc_rd_addr];
   end

   // --------------------------------------------------
   // Bus side
   // --------------------------------------------------

   // Third read port, lane picked by the bus.
   always_ff @(posedge clk_x) begin : bus_port
      if (mem.bus_rd_lane) begin
         mem.bus_rd_data <= lane1_mem[mem.bus_rd_addr];
      end else begin
         mem.bus_rd_data <= lane0_mem[mem.bus_rd_addr];
      end
   end

   // The accumulator pipeline keeps three slots in flight.
   // A slot comes back only after a full pass, so the write of
   // one slot must never meet the read of the same word.
   property p_no_rw_clash;
      @(posedge clk_x)
         mem.acc_wr_en |-> (mem.acc_wr_addr != mem.acc_rd_addr);
   endproperty

   a_no_rw_clash : assert property (p_no_rw_clash)
      else $error("count_bank_ram: write and read hit word %0d together",
                  mem.acc_wr_addr);

endmodule

/* logic/ones_accumulator.sv */
`include "corr_ones_cfg.svh"

module ones_accumulator (
   input  logic                     clk_x,
   input  logic                     rst,
   input  logic                     enable_i,       // Acquisition running.
   input  logic                     switch_i,       // Bank switch request.
   input  corr_ones_pkg::ant_word_t antenna_i,      // One word per cycle.
   output logic                     active_bank_o,  // Bank being counted into.
   count_ram_if.acc                 ram
);
   import corr_ones_pkg::*;

   localparam slot_t last_slot = slot_t'(`CORR_SLOTS - 1);

   // Slot and bank control.
   slot_t     slot_q;
   logic      bank_q;
   logic      pending_q;   // Switch seen, waiting for the wrap.
   logic      clear_q;     // First pass in a fresh bank.
   logic      wrap;

   // Antenna lanes.
   logic [`CORR_SLOTS-1:0] lane0;
   logic [`CORR_SLOTS-1:0] lane1;

   // Stage one, read issued.
   logic      s1_vld_q;
   logic      s1_clr_q;
   logic      s1_bit0_q;
   logic      s1_bit1_q;
   ram_addr_t s1_addr_q;

   // Stage two, sums ready for write back.
   logic      s2_vld_q;
   ram_addr_t s2_addr_q;
   count_t    s2_sum0_q;
   count_t    s2_sum1_q;

   // Count read back, or zero in a fresh bank.
   count_t    base0;
   count_t    base1;

   assign {lane1, lane0} = antenna_i;          // Lane 0 in the low half.
   assign wrap           = (slot_q == last_slot);
   assign active_bank_o  = bank_q;

   // --------------------------------------------------
   // Slot counter and bank switching
   // --------------------------------------------------

   // One slot per enabled cycle, 0 to 11.
   always_ff @(posedge clk_x) begin
      if (rst) begin
         slot_q <= '0;
      end else if (enable_i) begin
         slot_q <= wrap ? '0 : slot_q + slot_t'(1);
      end
   end

   // Flip only at an enabled wrap, so a pass never splits across banks.
   always_ff @(posedge clk_x) begin
      if (rst) begin
         bank_q    <= 1'b0;
         pending_q <= 1'b0;
         clear_q   <= 1'b1;   // Bank 0 starts from zero.
      end else if (enable_i && wrap && (switch_i || pending_q)) begin
         bank_q    <= ~bank_q;
         pending_q <= 1'b0;
         clear_q   <= 1'b1;   // New bank zeroes itself on its first pass.
      end else begin
         if (switch_i) begin
            pending_q <= 1'b1;
         end
         if (enable_i && wrap && clear_q) begin
            clear_q <= 1'b0;  // Whole bank has been rewritten.
         end
      end
   end

   // --------------------------------------------------
   // Read, add, write pipeline
   // --------------------------------------------------

   // Read the current slot of the active bank every cycle.
   assign ram.acc_rd_addr = {bank_q, slot_q};

   // Valid chain. Only enabled cycles enter.
   always_ff @(posedge clk_x) begin
      if (rst) begin
         s1_vld_q <= 1'b0;
         s2_vld_q <= 1'b0;
      end else begin
         s1_vld_q <= enable_i;
         s2_vld_q <= s1_vld_q;  // In-flight items finish without enable.
      end
   end

   // Latch the slot's antenna bits alongside the read.
   always_ff @(posedge clk_x) begin
      if (enable_i) begin
         s1_addr_q <= ram.acc_rd_addr;
         s1_clr_q  <= clear_q;  // Travels with the item across the wrap.
         s1_bit0_q <= lane0[slot_q];
         s1_bit1_q <= lane1[slot_q];
      end
   end

   assign base0 = s1_clr_q ? '0 : ram.acc_rd_data0;
   assign base1 = s1_clr_q ? '0 : ram.acc_rd_data1;

   // Add the ones. Two lanes per cycle.
   always_ff @(posedge clk_x) begin
      s2_addr_q <= s1_addr_q;
      s2_sum0_q <= base0 + count_t'(s1_bit0_q);
      s2_sum1_q <= base1 + count_t'(s1_bit1_q);
   end

   // Write back to the word the read used.
   assign ram.acc_wr_en    = s2_vld_q;
   assign ram.acc_wr_addr  = s2_addr_q;
   assign ram.acc_wr_data0 = s2_sum0_q;
   assign ram.acc_wr_data1 = s2_sum1_q;

   // Slot stays inside one pass.
   a_slot_range : assert property (
      @(posedge clk_x) disable iff (rst) slot_q <= last_slot)
      else $error("ones_accumulator: slot %0d out of range", slot_q);

   // Every write goes back to the word a read issued two edges before.
   a_wr_after_rd : assert property (
      @(posedge clk_x) disable iff (rst)
         ram.acc_wr_en |-> $past(enable_i && !rst, 2) &&
                           (ram.acc_wr_addr == $past(ram.acc_rd_addr, 2)))
      else $error("ones_accumulator: write without a matching read");

endmodule

/* logic/count_readout.sv */
`include "corr_ones_cfg.svh"

module count_readout (
   input  logic                    clk_x,
   input  logic                    rst,
   input  logic                    cyc_i,          // Bus cycle open.
   input  logic                    stb_i,          // Transfer strobe.
   input  logic                    we_i,           // Writes are acked only.
   input  corr_ones_pkg::bus_adr_t adr_i,          // Lane bit, then slot.
   input  logic                    active_bank_i,  // Bank being counted into.
   output logic                    ack_o,
   output corr_ones_pkg::count_t   dat_o,
   count_ram_if.rdout              ram
);
   import corr_ones_pkg::*;

   bus_state_e state_q;
   logic       start;   // New transfer accepted this cycle.
   logic       we_q;    // Transfer in progress is a write.

   // Accept in idle, or once the previous ack has gone by.
   assign start = cyc_i && stb_i &&
                  ((state_q == BUS_IDLE) || ((state_q == BUS_WAIT) && !ack_o));

   // --------------------------------------------------
   // Bus FSM
   // --------------------------------------------------

   // Strobe edge, then memory read edge, then ack edge.
   always_ff @(posedge clk_x) begin
      if (rst) begin
         state_q <= BUS_IDLE;
         ack_o   <= 1'b0;
      end else begin
         ack_o <= 1'b0;                 // Ack lasts one cycle.
         case (state_q)
            BUS_IDLE: begin
               if (start) begin
                  state_q <= BUS_READ;
               end
            end
            BUS_READ: begin
               state_q <= BUS_ACK;        // Memory samples the address.
            end
            BUS_ACK: begin
               state_q <= BUS_WAIT;
               ack_o   <= 1'b1;           // Data goes out with the ack.
            end
            BUS_WAIT: begin
               if (start) begin
                  state_q <= BUS_READ;    // Back-to-back transfer.
               end else if (!cyc_i) begin
                  state_q <= BUS_IDLE;
               end
            end
            default: begin
               state_q <= BUS_IDLE;
            end
         endcase
      end
   end

   // Only the inactive bank is read, the active one is busy counting.
   always_ff @(posedge clk_x) begin
      if (start) begin
         ram.bus_rd_addr <= {~active_bank_i, adr_i[$bits(slot_t)-1:0]};
         ram.bus_rd_lane <= adr_i[`CORR_ADR_W-1];
         we_q            <= we_i;
      end
      if ((state_q == BUS_ACK) && !we_q) begin
         dat_o <= ram.bus_rd_data;      // Holds until the next read.
      end
   end

   // Single-cycle ack, two cycles after the edge that took the strobe.
   a_ack_single : assert property (
      @(posedge clk_x) disable iff (rst) ack_o |-> !$past(ack_o) && $past(start, 3))
      else $error("count_readout: ack held or not tied to a strobe");

endmodule

/* logic/corr_ones_top.sv */
module corr_ones_top (
   input  logic                     clk_x,
   input  logic                     rst,

   // Antenna side.
   input  logic                     enable_i,   // Acquisition running.
   input  logic                     switch_i,   // Switch banks at next wrap.
   input  corr_ones_pkg::ant_word_t antenna_i,

   // Readout bus.
   input  logic                     cyc_i,
   input  logic                     stb_i,
   input  logic                     we_i,
   input  corr_ones_pkg::bus_adr_t  adr_i,
   output logic                     ack_o,
   output corr_ones_pkg::count_t    dat_o,

   // Active bank, so software sees when a switch has taken place.
   output logic                     bank_o
);

   // --------------------------------------------------
   // Count memory and its clients
   // --------------------------------------------------

   count_ram_if ram_if ();

   // Two lanes, two banks.
   count_bank_ram u_count_bank_ram (
      .clk_x (clk_x),
      .mem   (ram_if)
   );

   // Slot walk and the read, add, write pipeline.
   ones_accumulator u_ones_accumulator (
      .clk_x         (clk_x),
      .rst           (rst),
      .enable_i      (enable_i),
      .switch_i      (switch_i),
      .antenna_i     (antenna_i),
      .active_bank_o (bank_o),
      .ram           (ram_if)
   );

   // Bus reads from the bank opposite bank_o.
   count_readout u_count_readout (
      .clk_x         (clk_x),
      .rst           (rst),
      .cyc_i         (cyc_i),
      .stb_i         (stb_i),
      .we_i          (we_i),
      .adr_i         (adr_i),
      .active_bank_i (bank_o),
      .ack_o         (ack_o),
      .dat_o         (dat_o),
      .ram           (ram_if)
   );

endmodule

/* test/tb_corr_ones.sv */
`include "corr_ones_cfg.svh"

module tb_corr_ones;
   timeunit 1ns;
   timeprecision 100ps;

   import corr_ones_pkg::*;

   localparam int slots        = `CORR_SLOTS;
   localparam int interval_cyc = 60;   // Five passes when always enabled.
   localparam int n_intervals  = 6;
   localparam int hold_max     = 6;    // Longest switch request window.
   localparam int ack_limit    = 8;    // Cycles allowed for an ack.
   localparam int flip_limit   = 100;  // Cycles allowed for the bank flip.
   localparam int read_cyc     = (2 * slots + 1) * (ack_limit + 2) + 1;
   localparam int max_cycles   = 2 * 8 + 4 + n_intervals *
      (interval_cyc + slots + hold_max + flip_limit + 4 + read_cyc);

   logic      clk_x;
   logic      rst;
   logic      enable_i;
   logic      switch_i;
   ant_word_t antenna_i;
   logic      cyc_i;
   logic      stb_i;
   logic      we_i;
   bus_adr_t  adr_i;
   logic      ack_o;
   count_t    dat_o;
   logic      bank_o;

   int     en_mode;    // 0 always on, 1 random gaps, 2 off.
   int     off_left;   // Cycles left in a gap.
   logic   sw_drive;   // Value for switch_i.

   // Reference model state.
   count_t m_cnt [2][2][slots];  // Bank, lane, slot.
   int     m_slot;
   logic   m_bank;
   logic   m_pending;
   logic   m_clear;

   int     checks;
   int     value_errs;
   int     proto_errs;
   int     flips;              // bank_o changes seen by the DUT.
   logic   prev_bank;

   corr_ones_top u_dut (
      .clk_x     (clk_x),
      .rst       (rst),
      .enable_i  (enable_i),
      .switch_i  (switch_i),
      .antenna_i (antenna_i),
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .we_i      (we_i),
      .adr_i     (adr_i),
      .ack_o     (ack_o),
      .dat_o     (dat_o),
      .bank_o    (bank_o)
   );

   initial begin
      clk_x = 1'b0;
      forever #50 clk_x = ~clk_x;
   end

   // --------------------------------------------------
   // Reference model, one call per rising edge
   // --------------------------------------------------

   task automatic model_step(input logic en, input logic sw, input ant_word_t word);
      logic wrap;
      wrap = (m_slot == slots - 1);
      if (rst) begin
         m_slot    = 0;
         m_bank    = 1'b0;
         m_pending = 1'b0;
         m_clear   = 1'b1;
      end else begin
         if (en) begin
            for (int l = 0; l < 2; l++) begin
               m_cnt[m_bank][l][m_slot] = (m_clear ? '0 : m_cnt[m_bank][l][m_slot]) +
                                          count_t'(word[l * slots + m_slot]);
            end
         end
         if (en && wrap && (sw || m_pending)) begin
            m_bank    = ~m_bank;   // Flip at the wrap, fresh bank clears.
            m_pending = 1'b0;
            m_clear   = 1'b1;
         end else begin
            if (sw) m_pending = 1'b1;
            if (en && wrap && m_clear) m_clear = 1'b0;
         end
         if (en) m_slot = wrap ? 0 : m_slot + 1;
      end
   endtask

   function automatic logic pick_enable();
      logic en;
      en = 1'b1;
      if (en_mode == 2) begin
         en = 1'b0;
      end else if (en_mode == 1) begin
         if (off_left > 0) begin
            en = 1'b0;
            off_left--;
         end else if ($urandom % 6 == 0) begin
            en       = 1'b0;
            off_left = $urandom % 5;   // Gap of one to five cycles.
         end
      end
      return en;
   endfunction

   // Drive the next edge's inputs, step the model, wait past the edge.
   task automatic cycle();
      logic      en;
      ant_word_t word;
      en        = pick_enable();
      word      = ant_word_t'($urandom);
      enable_i  = en;
      switch_i  = sw_drive;
      antenna_i = word;
      model_step(en, sw_drive, word);
      @(posedge clk_x);
      #10;
      if (bank_o !== prev_bank) flips++;
      prev_bank = bank_o;
      checks++;
      assert (bank_o === m_bank) else begin
         value_errs++;
         $display("ERROR %0t: bank_o is %0d, model expects %0d", $time, bank_o, m_bank);
      end
   endtask

   // --------------------------------------------------
   // Bus transfers
   // --------------------------------------------------

   task automatic bus_transfer(input logic we, input logic lane, input int slot,
                               output count_t data);
      int waited;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = {lane, slot_t'(slot)};
      cycle();                        // Strobe sampled here.
      stb_i  = 1'b0;
      we_i   = 1'b0;
      waited = 0;
      while (!ack_o && waited < ack_limit) begin
         cycle();
         waited++;
      end
      checks++;
      assert (ack_o) else begin
         proto_errs++;
         $display("Bus transfer at %0t was never acknowledged", $time);
      end
      assert (waited == 2) else begin
         proto_errs++;
         $display("ERROR %0t: ack after %0d cycles, expected 2", $time, waited);
      end
      data = dat_o;
      cycle();
      assert (!ack_o) else begin
         proto_errs++;
         $display("ERROR %0t: ack_o high for a second cycle", $time);
      end
      assert (dat_o === data) else begin
         proto_errs++;
         $display("ERROR %0t: dat_o %0d moved after ack, was %0d", $time, dat_o, data);
      end
   endtask

   // One write, then all 24 counts of the inactive bank back to back.
   task automatic read_bank();
      count_t got;
      count_t prev;
      count_t exp;
      prev = dat_o;
      bus_transfer(1'b1, 1'($urandom % 2), $urandom % slots, got);
      assert (got === prev) else begin
         proto_errs++;
         $display("ERROR %0t: write changed dat_o to %0d", $time, got);
      end
      for (int l = 0; l < 2; l++) begin
         for (int s = 0; s < slots; s++) begin
            bus_transfer(1'b0, 1'(l), s, got);
            exp = m_cnt[~m_bank][l][s];
            checks++;
            assert (got == exp) else begin
               value_errs++;
               $display("ERROR %0t: lane %0d slot %0d read %0d, expected %0d",
                        $time, l, s, got, exp);
            end
         end
      end
      cyc_i = 1'b0;   // Close the cycle, FSM back to idle.
      cycle();
   endtask

   // --------------------------------------------------
   // Switch, reset and sequence
   // --------------------------------------------------

   task automatic switch_banks();
      logic start_bank;
      int   hold;
      int   guard;
      start_bank = bank_o;
      flips      = 0;
      repeat ($urandom % slots) cycle();   // Random starting slot.
      hold = 1 + $urandom % hold_max;
      for (int i = 0; i < hold && m_bank == start_bank; i++) begin
         sw_drive = (i == 0) || ($urandom % 2 == 1);  // Held or repeated.
         cycle();
      end
      sw_drive = 1'b0;
      guard    = 0;
      while (bank_o == start_bank && guard < flip_limit) begin
         cycle();
         guard++;
      end
      assert (bank_o != start_bank) else begin
         proto_errs++;
         $display("Bank switch requested at %0t never took place", $time);
      end
      repeat (4) cycle();                  // Drain the pipeline.
      checks++;
      assert (flips == 1) else begin
         value_errs++;
         $display("ERROR %0t: %0d bank flips, expected 1", $time, flips);
      end
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      repeat (8) begin
         cycle();
         checks++;
         assert (!ack_o) else begin   // An open read must not finish under reset.
            proto_errs++;
            $display("ERROR %0t: ack_o high during reset", $time);
         end
      end
      rst = 1'b0;
      checks++;
      assert (!ack_o && !bank_o) else begin
         proto_errs++;
         $display("ERROR %0t: after reset ack_o %0d bank_o %0d", $time, ack_o, bank_o);
      end
   endtask

   task automatic run_interval();
      repeat (interval_cyc) cycle();
      switch_banks();
      read_bank();
   endtask

   initial begin : main
      void'($urandom(71382));
      rst        = 1'b1;
      enable_i   = 1'b0;
      switch_i   = 1'b0;
      antenna_i  = '0;
      cyc_i      = 1'b0;
      stb_i      = 1'b0;
      we_i       = 1'b0;
      adr_i      = '0;
      en_mode    = 0;
      off_left   = 0;
      sw_drive   = 1'b0;
      checks     = 0;
      value_errs = 0;
      proto_errs = 0;
      flips      = 0;
      prev_bank  = 1'b0;
      m_cnt      = '{default: '0};
      model_step(1'b0, 1'b0, '0);   // Model into its reset state.

      apply_reset();
      repeat (3) run_interval();    // Always enabled. Third read checks the clear.
      en_mode = 1;
      repeat (2) run_interval();    // Random enable gaps.
      en_mode = 2;
      repeat (3) cycle();           // Empty pipeline before reset.
      cyc_i = 1'b1;                 // Read still open when reset hits.
      stb_i = 1'b1;
      cycle();
      stb_i = 1'b0;
      apply_reset();
      cyc_i = 1'b0;
      en_mode = 1;
      run_interval();

      $display("Checks %0d, value errors %0d, protocol errors %0d",
               checks, value_errs, proto_errs);
      if (value_errs + proto_errs == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(max_cycles * 100 + 10000);
      $display("Timeout: run did not finish within %0d cycles", max_cycles);
      $display("Checks %0d, value errors %0d, protocol errors %0d",
               checks, value_errs, proto_errs);
      $display("Test failed");
      $finish;
   end

endmodule

/* corr_ones.f */
+incdir+include
logic/corr_ones_pkg.sv
logic/count_ram_if.sv
logic/count_bank_ram.sv
logic/ones_accumulator.sv
logic/count_readout.sv
logic/corr_ones_top.sv
test/tb_corr_ones.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_corr_ones -f corr_ones.f

out="$(./obj_dir/Vtb_corr_ones)"
echo "$out"

grep -qx "Test passed" <<< "$out"
